// File: build.f
+incdir+source
+incdir+tb
source/neuronPkg.sv
source/fpMultiplier.sv
source/fpAdder.sv
source/termCounter.sv
source/neuronControl.sv
source/neuronRegs.sv
source/neuronTop.sv
tb/neuronTb.sv

// File: Makefile
TOP = neuronTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f \
		-Mdir obj_dir -o neuronSim
	./obj_dir/neuronSim | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/neuronRefModel.svh
`ifndef NEURON_REF_MODEL_SVH
`define NEURON_REF_MODEL_SVH

typedef fp32T fpBankT [`NEURON_MAX_INPUTS];

//////////////////////////////////////////////////////////////////////
// Single precision arithmetic with truncation and flush to zero
//////////////////////////////////////////////////////////////////////

function automatic fp32T refMul(input fp32T x, input fp32T y);
	fp32T r;
	logic [47:0] sig;
	int e;
	r = '0;
	r.sign = x.sign ^ y.sign;
	if ((x.exponent == 8'd0) || (y.exponent == 8'd0))
		return r; // A subnormal factor makes a signed zero.
	sig = 48'({1'b1, x.mantissa}) * 48'({1'b1, y.mantissa});
	e = int'(x.exponent) + int'(y.exponent) - 127;
	if (sig[47])
	begin
		e = e + 1;
		sig = sig >> 1;
	end
	if (e <= 0)
		return r;
	if (e >= 255)
	begin
		r.exponent = 8'hFF;
		return r;
	end
	r.exponent = 8'(e);
	r.mantissa = sig[45:23]; // Bits below the kept fraction are dropped.
	return r;
endfunction

function automatic fp32T refAdd(input fp32T x, input fp32T y);
	fp32T bigOp;
	fp32T smallOp;
	logic [27:0] mag;
	logic [27:0] part;
	int top;
	int e;
	if (x.exponent == 8'd0)
		x = '0;
	if (y.exponent == 8'd0)
		y = '0;
	bigOp = x;
	smallOp = y;
	if ({y.exponent, y.mantissa} > {x.exponent, x.mantissa})
	begin
		bigOp = y;
		smallOp = x;
	end
	// Alignment keeps three bits below the fraction and truncates the rest.
	mag = 28'({bigOp.exponent != 8'd0, bigOp.mantissa, 3'b000});
	part = 28'({smallOp.exponent != 8'd0, smallOp.mantissa, 3'b000})
		>> (bigOp.exponent - smallOp.exponent);
	mag = (bigOp.sign == smallOp.sign) ? mag + part : mag - part;
	if (mag == 28'd0)
		return '0;
	top = 0;
	for (int i = 0; i < 28; i++)
	begin
		if (mag[i])
			top = i;
	end
	e = int'(bigOp.exponent) + top - 26; // The hidden bit starts at position 26.
	bigOp.exponent = 8'(e);
	bigOp.mantissa = (top >= 23) ? 23'(mag >> (top - 23)) : 23'(mag << (23 - top));
	if ((e <= 0) || (e >= 255))
	begin
		bigOp.exponent = (e <= 0) ? 8'd0 : 8'hFF;
		bigOp.mantissa = 23'd0;
	end
	return bigOp;
endfunction

// Bias first, then the products in index order, then the ReLU stage.
function automatic fp32T refNeuron(input fpBankT act, input fpBankT wgt, input fp32T bias,
	input int count);
	fp32T acc;
	acc = bias;
	for (int i = 0; i < count; i++)
		acc = refAdd(acc, refMul(act[i], wgt[i]));
	if (acc.sign)
		acc = '0;
	return acc;
endfunction

`endif

// File: tb/neuronTb.sv
`timescale 1ns/1ps
`include "neuron_defs.svh"

module neuronTb;
	import neuronPkg::*;

	`include "neuronRefModel.svh"

	localparam int runBudget = 3 * 2 * `NEURON_MAX_INPUTS + 60; // Two banks, 3 cycles a transfer.
	localparam int runCount = 29;
	localparam int cycleLimit = 2 * runCount * runBudget;

	logic clk;
	logic rst;
	apbReqT req;
	apbRspT rsp;
	fpBankT actMem;
	fpBankT wgtMem;
	fp32T biasMem;
	fp32T expQ [$];
	fp32T gotQ [$];
	int cycleCount = 0;

	neuronTop dut0 (.clk(clk), .rst(rst), .req(req), .rsp(rsp));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped.");
	endtask

	task automatic checkFp(input fp32T got, input fp32T exp, input string what);
		if (got !== exp)
			reportFailure($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportFailure($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			reportFailure($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
			reportFailure("Timeout: the run went past its cycle limit without finishing.");
	end

	always @(posedge clk)
	begin
		while (gotQ.size() > 0)
		begin
			if (expQ.size() == 0)
				reportFailure("A result was read back with no expected value queued.");
			else
				checkFp(gotQ.pop_front(), expQ.pop_front(), "neuron result");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// APB driver
	//////////////////////////////////////////////////////////////////////

	task automatic apbTransfer(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		req = '{sel: 1'b1, enable: 1'b0, write: write, addr: addr, wdata: wdata};
		@(negedge clk);
		req.enable = 1'b1;
		#1;
		rdata = rsp.rdata; // Sampled mid phase, well before the rising edge.
		err = rsp.slverr;
		checkFlag(rsp.ready, 1'b1, $sformatf("ready in access phase at %h", addr));
		@(negedge clk);
		req = '0;
	endtask

	task automatic writeReg(input logic [11:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] unused;
		logic err;
		apbTransfer(1'b1, addr, data, unused, err);
		checkFlag(err, expErr, $sformatf("slverr on write to %h", addr));
	endtask

	task automatic readReg(input logic [11:0] addr, output logic [31:0] data, input logic expErr);
		logic err;
		apbTransfer(1'b0, addr, 32'd0, data, err);
		checkFlag(err, expErr, $sformatf("slverr on read of %h", addr));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Neuron sequences
	//////////////////////////////////////////////////////////////////////

	function automatic fp32T randomOperand();
		fp32T v;
		v.sign = 1'($urandom_range(0, 1));
		v.exponent = 8'(120 + $urandom_range(0, 15));
		v.mantissa = 23'($urandom);
		return v;
	endfunction

	task automatic fillRandom();
		for (int i = 0; i < `NEURON_MAX_INPUTS; i++)
		begin
			actMem[i] = randomOperand();
			wgtMem[i] = randomOperand();
		end
		biasMem = randomOperand();
	endtask

	task automatic loadBanks();
		for (int i = 0; i < `NEURON_MAX_INPUTS; i++)
		begin
			writeReg(12'(`ADDR_ACT_BASE + 4 * i), actMem[i], 1'b0);
			writeReg(12'(`ADDR_WGT_BASE + 4 * i), wgtMem[i], 1'b0);
		end
		writeReg(`ADDR_BIAS, biasMem, 1'b0);
	endtask

	task automatic startNeuron(input int count);
		expQ.push_back(refNeuron(actMem, wgtMem, biasMem, count));
		writeReg(`ADDR_CTRL, 32'd1, 1'b0);
	endtask

	task automatic finishNeuron();
		logic [31:0] data;
		do
			readReg(`ADDR_STATUS, data, 1'b0);
		while (!data[1]);
		checkWord(data, 32'h2, "status when done"); // Busy drops as done rises.
		readReg(`ADDR_RESULT, data, 1'b0);
		gotQ.push_back(data);
	endtask

	task automatic runNeuron(input int count);
		writeReg(`ADDR_COUNT, 32'(count), 1'b0);
		startNeuron(count);
		finishNeuron();
	endtask

	initial
	begin
		int partialCounts [3];
		logic [31:0] data;
		partialCounts = '{1, 7, 49};
		void'($urandom(32'hc944));
		rst = 1'b1;
		req = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		readReg(`ADDR_STATUS, data, 1'b0);
		checkWord(data, 32'd0, "status after reset");
		readReg(`ADDR_RESULT, data, 1'b0);
		checkWord(data, 32'd0, "result after reset");
		readReg(`ADDR_COUNT, data, 1'b0);
		checkWord(data, 32'(`NEURON_MAX_INPUTS), "count after reset");

		repeat (20)
		begin
			fillRandom();
			loadBanks();
			runNeuron(`NEURON_MAX_INPUTS);
		end
		foreach (partialCounts[k])
		begin
			fillRandom();
			loadBanks();
			runNeuron(partialCounts[k]);
		end

		// ReLU stage with 5 terms of 1.0 times 2.0 and a bias of -100 and then +100.
		for (int i = 0; i < `NEURON_MAX_INPUTS; i++)
		begin
			actMem[i] = 32'h3F800000;
			wgtMem[i] = 32'h40000000;
		end
		biasMem = 32'hC2C80000;
		loadBanks();
		runNeuron(5);
		biasMem = 32'h42C80000;
		writeReg(`ADDR_BIAS, biasMem, 1'b0);
		runNeuron(5);

		actMem[0] = 32'h00001234; // Subnormal activations.
		actMem[1] = 32'h80400000;
		actMem[2] = 32'h007FFFFF;
		for (int i = 0; i < 3; i++)
			wgtMem[i] = 32'h7F000000; // Weights of 2^127 lift any unflushed subnormal near 1.0.
		biasMem = 32'h3F800000;
		loadBanks();
		runNeuron(3);
		actMem[0] = 32'h3FC00000; // 1.5 times 2.5 cancels a bias of -3.75.
		wgtMem[0] = 32'h40200000;
		biasMem = 32'hC0700000;
		loadBanks();
		runNeuron(1);
		actMem[0] = 32'h71800000; // 2^100 squared overflows.
		wgtMem[0] = 32'h71800000;
		biasMem = 32'h3F800000;
		loadBanks();
		runNeuron(1);

		fillRandom();
		loadBanks();
		writeReg(12'h020, 32'h1, 1'b1);
		readReg(12'h300, data, 1'b1);
		writeReg(12'(`ADDR_ACT_BASE + 4 * `NEURON_MAX_INPUTS), 32'h1, 1'b1);
		writeReg(`ADDR_COUNT, 32'(`NEURON_MAX_INPUTS), 1'b0);
		writeReg(`ADDR_COUNT, 32'd0, 1'b1);
		writeReg(`ADDR_COUNT, 32'(`NEURON_MAX_INPUTS + 1), 1'b1);
		readReg(`ADDR_COUNT, data, 1'b0);
		checkWord(data, 32'(`NEURON_MAX_INPUTS), "count after rejected writes");
		startNeuron(`NEURON_MAX_INPUTS);
		readReg(`ADDR_STATUS, data, 1'b0);
		checkWord(data, 32'h1, "status while busy");
		writeReg(`ADDR_ACT_BASE, 32'h12345678, 1'b1);
		writeReg(`ADDR_WGT_BASE, 32'h12345678, 1'b1);
		writeReg(`ADDR_BIAS, 32'h12345678, 1'b1);
		writeReg(`ADDR_COUNT, 32'd10, 1'b1);
		writeReg(`ADDR_CTRL, 32'd1, 1'b1);
		finishNeuron();
		readReg(`ADDR_ACT_BASE, data, 1'b0);
		checkFp(data, actMem[0], "activation 0 after busy write");
		readReg(`ADDR_WGT_BASE, data, 1'b0);
		checkFp(data, wgtMem[0], "weight 0 after busy write");
		readReg(`ADDR_BIAS, data, 1'b0);
		checkFp(data, biasMem, "bias after busy write");
		readReg(`ADDR_COUNT, data, 1'b0);
		checkWord(data, 32'(`NEURON_MAX_INPUTS), "count after busy write");

		@(posedge clk);
		@(negedge clk);
		if ((expQ.size() == 0) && (gotQ.size() == 0))
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
			reportFailure("Some neuron results were never compared.");
	end

endmodule

// File: source/neuronTop.sv
`timescale 1ns/1ps

module neuronTop
(
	input logic clk,
	input logic rst,
	input neuronPkg::apbReqT req,
	output neuronPkg::apbRspT rsp
);
	import neuronPkg::*;

	logic [5:0] index;
	logic [5:0] count;
	logic last;
	logic start;
	logic busy;
	logic done;
	logic resultWrite;
	logic counterLoad;
	logic counterEnable;
	fp32T bias;
	fp32T activation;
	fp32T weight;
	fp32T product;
	fp32T result;

	neuronRegs regs0 (
		.clk(clk), .rst(rst),
		.req(req), .rsp(rsp),
		.index(index),
		.busy(busy), .done(done),
		.resultWrite(resultWrite), .result(result),
		.start(start), .count(count),
		.bias(bias), .activation(activation), .weight(weight)
	);

	termCounter counter0 (
		.clk(clk), .rst(rst),
		.load(counterLoad), .enable(counterEnable),
		.count(count), .index(index), .last(last)
	);

	fpMultiplier mult0 (.clk(clk), .rst(rst), .a(activation), .b(weight), .product(product));

	neuronControl control0 (
		.clk(clk), .rst(rst),
		.start(start), .last(last),
		.product(product), .bias(bias),
		.counterLoad(counterLoad), .counterEnable(counterEnable),
		.busy(busy), .done(done),
		.resultWrite(resultWrite), .result(result)
	);

endmodule

// File: source/neuronRegs.sv
`timescale 1ns/1ps
`include "neuron_defs.svh"

module neuronRegs
(
	input logic clk,
	input logic rst,
	input neuronPkg::apbReqT req,
	output neuronPkg::apbRspT rsp,
	input logic [5:0] index,
	input logic busy,
	input logic done,
	input logic resultWrite,
	input neuronPkg::fp32T result,
	output logic start,
	output logic [5:0] count,
	output neuronPkg::fp32T bias,
	output neuronPkg::fp32T activation,
	output neuronPkg::fp32T weight
);
	import neuronPkg::*;

	fp32T actBank [`NEURON_MAX_INPUTS];
	fp32T wgtBank [`NEURON_MAX_INPUTS];
	fp32T resultReg;
	logic access;
	logic wrAccess;
	logic wrOk;
	logic [5:0] entry;
	logic hitCtrl;
	logic hitStatus;
	logic hitBias;
	logic hitCount;
	logic hitResult;
	logic hitAct;
	logic hitWgt;
	logic wrError;
	logic slverr;
	logic [31:0] readData;

	assign access = req.sel && req.enable;
	assign wrAccess = access && req.write;
	assign entry = req.addr[7:2];

	assign hitCtrl = (req.addr == `ADDR_CTRL);
	assign hitStatus = (req.addr == `ADDR_STATUS);
	assign hitBias = (req.addr == `ADDR_BIAS);
	assign hitCount = (req.addr == `ADDR_COUNT);
	assign hitResult = (req.addr == `ADDR_RESULT);
	assign hitAct = ((req.addr & 12'hF03) == `ADDR_ACT_BASE) && (entry < `NEURON_MAX_INPUTS);
	assign hitWgt = ((req.addr & 12'hF03) == `ADDR_WGT_BASE) && (entry < `NEURON_MAX_INPUTS);

	// Operands and start are locked while busy; the count must be in range.
	assign wrError = wrAccess && ((busy && (hitBias || hitCount || hitAct || hitWgt
		|| (hitCtrl && req.wdata[0])))
		|| (hitCount && ((req.wdata == 32'd0) || (req.wdata > `NEURON_MAX_INPUTS))));
	assign slverr = (access && !(hitCtrl || hitStatus || hitBias || hitCount || hitResult
		|| hitAct || hitWgt)) || wrError;
	assign wrOk = wrAccess && !slverr;
	assign start = wrOk && hitCtrl && req.wdata[0];

	always_ff @(posedge clk)
	begin
		if (wrOk && hitAct)
			actBank[entry] <= req.wdata;
		if (wrOk && hitWgt)
			wgtBank[entry] <= req.wdata;
		if (wrOk && hitBias)
			bias <= req.wdata;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= 6'(`NEURON_MAX_INPUTS);
			resultReg <= '0;
		end
		else
		begin
			if (wrOk && hitCount)
				count <= req.wdata[5:0];
			if (resultWrite)
				resultReg <= result;
		end
	end

	always_comb
	begin
		readData = 32'd0; // CTRL and unmapped addresses read as zero.
		if (hitStatus)
			readData = {30'd0, done, busy};
		else if (hitBias)
			readData = bias;
		else if (hitCount)
			readData = {26'd0, count};
		else if (hitResult)
			readData = resultReg;
		else if (hitAct)
			readData = actBank[entry];
		else if (hitWgt)
			readData = wgtBank[entry];
	end

	assign rsp = '{rdata: readData, ready: 1'b1, slverr: slverr};

	assign activation = actBank[index];
	assign weight = wgtBank[index];

	assert property (@(posedge clk) disable iff (rst) req.enable |-> req.sel)
		else $error("neuronRegs: APB enable without sel.");

endmodule

// File: source/neuronControl.sv
`timescale 1ns/1ps

module neuronControl
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic last,
	input neuronPkg::fp32T product,
	input neuronPkg::fp32T bias,
	output logic counterLoad,
	output logic counterEnable,
	output logic busy,
	output logic done,
	output logic resultWrite,
	output neuronPkg::fp32T result
);
	import neuronPkg::*;

	ctrlStateT state;
	ctrlStateT stateNext;
	logic productValid;
	logic accClear;
	logic accEnable;
	fp32T acc;
	fp32T accSum;

	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE: if (start) stateNext = PRIME;
			PRIME: stateNext = RUN;
			RUN: if (last) stateNext = DRAIN;
			DRAIN: stateNext = FINISH;
			FINISH: stateNext = IDLE;
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			productValid <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			productValid <= (state == RUN); // Multiplier output is one cycle behind.
			if (start)
				done <= 1'b0;
			else if (state == FINISH)
				done <= 1'b1;
		end
	end

	assign counterLoad = (state == PRIME);
	assign counterEnable = (state == RUN);
	assign busy = (state != IDLE);
	assign resultWrite = (state == FINISH);
	assign accClear = (state == PRIME);
	assign accEnable = productValid;

	//////////////////////////////////////////////////////////////////////
	// Accumulator
	//////////////////////////////////////////////////////////////////////

	fpAdder adder0 (.a(acc), .b(product), .sum(accSum));

	always_ff @(posedge clk)
	begin
		if (accClear)
			acc <= bias; // Summation starts at the bias.
		else if (accEnable)
			acc <= accSum;
	end

	assign result = acc.sign ? '0 : acc; // Rectified linear output.

	assert property (@(posedge clk) disable iff (rst) start |-> (state == IDLE))
		else $error("neuronControl: start received while not idle.");

endmodule

// File: source/termCounter.sv
`timescale 1ns/1ps
`include "neuron_defs.svh"

module termCounter
#(
	parameter int depth = `NEURON_MAX_INPUTS
)
(
	input logic clk,
	input logic rst,
	input logic load,
	input logic enable,
	input logic [5:0] count,
	output logic [5:0] index,
	output logic last
);
	logic [5:0] limit;
	logic exhausted;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			limit <= 6'(depth);
			index <= 6'd0;
			exhausted <= 1'b0;
		end
		else if (load)
		begin
			limit <= count;
			index <= 6'd0;
			exhausted <= 1'b0;
		end
		else if (enable)
		begin
			if (last)
				exhausted <= 1'b1; // Index holds on the final term.
			else
				index <= index + 6'd1;
		end
	end

	assign last = (index == limit - 6'd1);

	assert property (@(posedge clk) disable iff (rst) !(enable && exhausted))
		else $error("termCounter: enable after the last term without a reload.");

endmodule

// File: source/fpAdder.sv
`timescale 1ns/1ps

module fpAdder
(
	input neuronPkg::fp32T a,
	input neuronPkg::fp32T b,
	output neuronPkg::fp32T sum
);
	import neuronPkg::*;

	fp32T opA;
	fp32T opB;
	fp32T opBig;
	fp32T opSmall;
	logic [7:0] expDiff;
	logic [26:0] sigBig;
	logic [26:0] sigSmall;
	logic [27:0] sigSum;
	logic [4:0] leadZeros;
	logic [27:0] sigNorm;
	logic signed [9:0] expRes;

	assign opA = (a.exponent == 8'd0) ? '0 : a; // Flush subnormals.
	assign opB = (b.exponent == 8'd0) ? '0 : b;

	//////////////////////////////////////////////////////////////////////
	// Order and align
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if ({opA.exponent, opA.mantissa} >= {opB.exponent, opB.mantissa})
		begin
			opBig = opA;
			opSmall = opB;
		end
		else
		begin
			opBig = opB;
			opSmall = opA;
		end
	end

	assign expDiff = opBig.exponent - opSmall.exponent;

	// Hidden bit, fraction and three guard bits.
	assign sigBig = {opBig.exponent != 8'd0, opBig.mantissa, 3'b000};
	assign sigSmall = {opSmall.exponent != 8'd0, opSmall.mantissa, 3'b000} >> expDiff;

	assign sigSum = (opBig.sign == opSmall.sign) ? {1'b0, sigBig} + {1'b0, sigSmall}
		: {1'b0, sigBig} - {1'b0, sigSmall};

	//////////////////////////////////////////////////////////////////////
	// Normalize
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		leadZeros = 5'd28;
		for (int i = 0; i < 28; i++)
		begin
			if (sigSum[i])
			begin
				leadZeros = 5'(27 - i); // The highest set bit wins.
			end
		end
	end

	assign sigNorm = sigSum << leadZeros;
	assign expRes = $signed({2'b00, opBig.exponent}) + 10'sd1 - $signed({5'b00000, leadZeros});

	always_comb
	begin
		sum.sign = opBig.sign;
		sum.exponent = expRes[7:0];
		sum.mantissa = sigNorm[26:4]; // Guard bits are truncated.
		if (sigSum == 28'd0)
		begin
			sum = '0; // Exact cancellation gives positive zero.
		end
		else if (expRes <= 10'sd0)
		begin
			sum.exponent = 8'd0;
			sum.mantissa = 23'd0;
		end
		else if (expRes >= 10'sd255)
		begin
			sum.exponent = 8'hFF;
			sum.mantissa = 23'd0;
		end
	end

endmodule

// File: source/fpMultiplier.sv
`timescale 1ns/1ps

module fpMultiplier
(
	input logic clk,
	input logic rst,
	input neuronPkg::fp32T a,
	input neuronPkg::fp32T b,
	output neuronPkg::fp32T product
);
	import neuronPkg::*;

	logic zeroIn;
	logic [47:0] sigProd;
	logic signed [9:0] expSum;
	fp32T prodNext;

	assign zeroIn = (a.exponent == 8'd0) || (b.exponent == 8'd0); // Subnormals act as zero.
	assign sigProd = {1'b1, a.mantissa} * {1'b1, b.mantissa};

	always_comb
	begin
		expSum = $signed({2'b00, a.exponent}) + $signed({2'b00, b.exponent}) - 10'sd127;
		prodNext.sign = a.sign ^ b.sign;
		if (sigProd[47])
		begin
			expSum = expSum + 10'sd1; // Significand product in [2,4) needs one shift.
			prodNext.mantissa = sigProd[46:24];
		end
		else
		begin
			prodNext.mantissa = sigProd[45:23];
		end
		prodNext.exponent = expSum[7:0];

		if (zeroIn || (expSum <= 10'sd0))
		begin
			prodNext.exponent = 8'd0; // Signed zero on underflow.
			prodNext.mantissa = 23'd0;
		end
		else if (expSum >= 10'sd255)
		begin
			prodNext.exponent = 8'hFF; // Saturate to infinity.
			prodNext.mantissa = 23'd0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			product <= '0;
		end
		else
		begin
			product <= prodNext;
		end
	end

	// The accumulator downstream relies on products being normal or exact zero.
	assert property (@(posedge clk) disable iff (rst)
		(product.exponent == 8'd0) |-> (product.mantissa == 23'd0))
		else $error("fpMultiplier: nonzero product carries a zero exponent.");

endmodule

// File: source/neuronPkg.sv
package neuronPkg;

	//////////////////////////////////////////////////////////////////////
	// Floating point payload
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic sign;
		logic [7:0] exponent;
		logic [22:0] mantissa;
	} fp32T;

	//////////////////////////////////////////////////////////////////////
	// APB
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		logic [11:0] addr;
		logic [31:0] wdata;
	} apbReqT;

	typedef struct packed {
		logic [31:0] rdata;
		logic ready;
		logic slverr;
	} apbRspT;

	// Controller states, in the order the sequence visits them.
	typedef enum logic [2:0] {
		IDLE,
		PRIME,
		RUN,
		DRAIN,
		FINISH
	} ctrlStateT;

endpackage

// File: source/neuron_defs.svh
`ifndef NEURON_DEFS_SVH
`define NEURON_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Neuron capacity
//////////////////////////////////////////////////////////////////////

`define NEURON_MAX_INPUTS 50 // Entries in each operand bank.

//////////////////////////////////////////////////////////////////////
// APB register map
//////////////////////////////////////////////////////////////////////

`define ADDR_CTRL     12'h000 // Writing bit 0 starts the neuron.
`define ADDR_STATUS   12'h004 // Bit 0 is busy, bit 1 is done.
`define ADDR_BIAS     12'h008
`define ADDR_COUNT    12'h00C // Number of active inputs.
`define ADDR_RESULT   12'h010
`define ADDR_ACT_BASE 12'h100 // Entry i sits at base plus 4 times i.
`define ADDR_WGT_BASE 12'h200

`endif
